//--- design/fds_bus_map.sv
// Combinational only; $4031 data comes from PRG memory through prg_aout, not from here
module fds_bus_map (
	input  fds_pkg::addr_t     prg_ain,
	input  logic               prg_read,
	input  logic               timer_irq,
	input  logic               byte_ready,
	input  logic               disk_end,
	input  logic               drive_ready,
	input  logic               eject_btn,
	input  logic               disk_access,
	input  fds_pkg::pos_t      disk_pos,
	output fds_pkg::data_t     prg_dout,
	output logic               prg_bus_write,
	output fds_pkg::prg_addr_t prg_aout,
	output logic               prg_allow
);
	import fds_pkg::*;

	logic                  prg_is_ram;
	logic [DISK_OFS_W-1:0] disk_offset;

	// $6000-$DFFF
	assign prg_is_ram = prg_ain[15] ^ (&prg_ain[14:13]);
	assign disk_offset = SIDE_OFFSET + DISK_OFS_W'(disk_pos);

	always_comb begin
		if (disk_access)
			prg_aout = {DISK_REGION_BASE, disk_offset};
		else if (prg_is_ram)
			prg_aout = {WRAM_BANK_BASE, prg_ain[14:0]}; // Bank from a[14:13]
		else
			prg_aout = {BIOS_BANK_BASE, prg_ain[12:0]};
	end

	always_comb begin
		prg_bus_write = 1'b1;
		case (prg_ain)
			REG_IRQ_STATUS:
				prg_dout = {1'b0, disk_end, 4'd0, byte_ready, timer_irq};
			// Bit 6 reads back as open bus high
			REG_DRIVE_STATUS:
				prg_dout = {4'h4, 1'b0, eject_btn, !drive_ready, eject_btn};
			REG_EXT_PORT:
				prg_dout = EXT_PORT_VALUE;
			default: begin
				prg_dout = '0;
				prg_bus_write = 1'b0;
			end
		endcase
	end

	// Upper reads the mapper does not answer go to memory
	assign prg_allow = (prg_read && prg_ain[15] && !prg_bus_write) || prg_is_ram ||
		disk_access;

endmodule

//--- design/fds_disk_drive.sv
// One side only; no CRC bytes in the image, so block ends come from the block type
module fds_disk_drive #(
	parameter logic [15:0] PRE_GAP_DELAY = 16'd65535,
	parameter logic [15:0] BYTE_DELAY    = 16'd99
) (
	input  logic           clk,
	input  logic           diskreset,
	input  logic           ce,
	input  fds_pkg::addr_t prg_ain,
	input  fds_pkg::data_t prg_din,
	input  fds_pkg::data_t prg_dbus,
	input  logic           prg_read,
	input  logic           prg_write,
	input  logic           eject_btn,
	output logic           io_enabled,
	output logic           status_read,
	output logic           byte_ready,
	output logic           disk_irq,
	output logic           disk_end,
	output logic           drive_ready,
	output logic           disk_access,
	output fds_pkg::pos_t  disk_pos,
	output logic           vertical
);
	import fds_pkg::*;

	logic        motor_on;
	logic        drive_rewind;
	logic        write_mode;
	logic        xfer_on;
	logic        irq_en;
	logic        new_byte;    // Slot not yet consumed by an access
	logic        got_start;
	logic        got_start_d;
	logic        after_pre_gap;
	logic        read_d;
	logic        write_d;
	logic        block_end;
	logic        last_hit;
	logic [15:0] xfer_cnt;
	pos_t        byte_cnt;
	pos_t        file_size;
	block_type_e block_type;
	logic        read_disk;
	logic        write_disk;
	logic        xfer_start;
	logic        step;
	data_t       disk_data;

	assign read_disk = prg_read && (prg_ain == REG_READ_DATA);
	assign write_disk = prg_write && (prg_ain == REG_WRITE_DATA) && write_mode && xfer_on &&
		got_start_d && motor_on && !drive_rewind && !block_end;
	assign disk_access = read_disk || write_disk;
	assign disk_data = write_disk ? prg_din : prg_dbus;
	assign disk_end = (disk_pos == DISK_END_POS);
	assign drive_ready = motor_on && !drive_rewind && !disk_end && !eject_btn;
	assign disk_irq = byte_ready && irq_en;
	assign xfer_start = prg_write && (prg_ain == REG_DRIVE_CTRL) && !xfer_on && prg_din[CTRL_XFER];
	assign step = ((read_d && !write_mode) || write_d) && new_byte; // One ce after the access

	always_comb begin
		case (block_type)
			BLK_VOLUME:      last_hit = (byte_cnt == VOLUME_LAST);
			BLK_FILE_COUNT:  last_hit = (byte_cnt == COUNT_LAST);
			BLK_FILE_HEADER: last_hit = (byte_cnt == HEADER_LAST);
			BLK_FILE_DATA:   last_hit = (byte_cnt == file_size);
			default:         last_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (diskreset) begin
			io_enabled <= 1'b0;
			motor_on <= 1'b0;
			drive_rewind <= 1'b0;
			write_mode <= 1'b0;
			vertical <= 1'b0;
			xfer_on <= 1'b0;
			irq_en <= 1'b0;
			byte_ready <= 1'b0;
			new_byte <= 1'b0;
			got_start <= 1'b0;
			got_start_d <= 1'b0;
			after_pre_gap <= 1'b0;
			status_read <= 1'b0;
			read_d <= 1'b0;
			write_d <= 1'b0;
			xfer_cnt <= '0;
			byte_cnt <= '0;
			block_end <= 1'b0;
			block_type <= BLK_NONE;
			disk_pos <= '0;
		end else if (ce) begin
			got_start_d <= got_start;
			read_d <= read_disk;
			write_d <= write_disk;
			status_read <= prg_read && (prg_ain == REG_IRQ_STATUS);

			if (status_read || read_d)
				byte_ready <= 1'b0;

			if ((read_disk && !write_mode) || write_disk) begin
				if (byte_cnt == '0)
					block_type <= block_type_e'(disk_data[2:0]);
				if (block_type == BLK_FILE_HEADER && byte_cnt == FSIZE_LO_OFS)
					file_size[7:0] <= disk_data;
				if (block_type == BLK_FILE_HEADER && byte_cnt == FSIZE_HI_OFS)
					file_size[15:8] <= disk_data;
			end

			if (step) begin
				new_byte <= 1'b0;
				byte_cnt <= byte_cnt + 1'b1;
				if (!disk_end && !block_end)
					disk_pos <= disk_pos + 1'b1;
				if (last_hit)
					block_end <= 1'b1;
			end

			// Gap and byte pacing
			if (drive_rewind) begin
				xfer_cnt <= '0;
				after_pre_gap <= 1'b0;
				disk_pos <= '0;
			end else if (!motor_on) begin
				xfer_cnt <= '0;
				after_pre_gap <= 1'b0;
			end else if (!after_pre_gap) begin
				if (xfer_cnt == PRE_GAP_DELAY) begin
					after_pre_gap <= 1'b1;
					xfer_cnt <= '0;
				end else begin
					xfer_cnt <= xfer_cnt + 1'b1;
				end
			end else if (xfer_cnt == BYTE_DELAY) begin
				xfer_cnt <= '0;
				if (xfer_on) begin
					byte_ready <= 1'b1; // Overwrites an unserviced slot
					new_byte <= 1'b1;
				end
			end else begin
				xfer_cnt <= xfer_cnt + 1'b1;
			end

			if (prg_write) begin
				case (prg_ain)
					REG_IO_ENABLE: io_enabled <= prg_din[0];
					REG_WRITE_DATA: begin
						byte_ready <= 1'b0;
						if (write_mode && xfer_on && prg_din == START_MARK)
							got_start <= 1'b1;
					end
					REG_DRIVE_CTRL: begin
						motor_on <= prg_din[CTRL_MOTOR];
						drive_rewind <= prg_din[CTRL_REWIND];
						write_mode <= !prg_din[CTRL_READ];
						vertical <= !prg_din[CTRL_MIRROR];
						xfer_on <= prg_din[CTRL_XFER];
						irq_en <= prg_din[CTRL_IRQ];
						if (xfer_start) begin
							byte_ready <= write_mode; // Writes may start at once
							new_byte <= 1'b0;
							got_start <= 1'b0;
							got_start_d <= 1'b0;
							byte_cnt <= '0;
							block_end <= 1'b0;
							block_type <= BLK_NONE;
							if (after_pre_gap)
								xfer_cnt <= '0;
						end
						if (!prg_din[CTRL_MOTOR])
							byte_ready <= 1'b0;
					end
					default: ;
				endcase
			end
		end
	end

	assert property (@(posedge clk) disable iff (diskreset) disk_pos <= DISK_END_POS)
		else $error("disk head past the end of the side");

	assert property (@(posedge clk) disable iff (diskreset) !motor_on |-> !byte_ready)
		else $error("byte ready with the motor off");

endmodule

//--- design/fds_pkg.sv
// Single disk side only; PRG space is 22 bits with the disk image region at $40000
package fds_pkg;

	typedef logic [15:0] addr_t;     // CPU address
	typedef logic [7:0]  data_t;     // CPU data
	typedef logic [21:0] prg_addr_t; // PRG memory address
	typedef logic [15:0] pos_t;      // Disk head position

	typedef enum logic [15:0] {
		REG_TIMER_LO     = 16'h4020,
		REG_TIMER_HI     = 16'h4021,
		REG_TIMER_CTRL   = 16'h4022,
		REG_IO_ENABLE    = 16'h4023,
		REG_WRITE_DATA   = 16'h4024,
		REG_DRIVE_CTRL   = 16'h4025,
		REG_IRQ_STATUS   = 16'h4030,
		REG_READ_DATA    = 16'h4031,
		REG_DRIVE_STATUS = 16'h4032,
		REG_EXT_PORT     = 16'h4033
	} reg_addr_e;

	// Block type is byte 0 of every block
	typedef enum logic [2:0] {
		BLK_NONE        = 3'd0,
		BLK_VOLUME      = 3'd1,
		BLK_FILE_COUNT  = 3'd2,
		BLK_FILE_HEADER = 3'd3,
		BLK_FILE_DATA   = 3'd4
	} block_type_e;

	localparam int TCTRL_REPEAT = 0; // $4022 bits
	localparam int TCTRL_ENABLE = 1;

	// $4025 bit positions
	localparam int CTRL_MOTOR  = 0;
	localparam int CTRL_REWIND = 1;
	localparam int CTRL_READ   = 2;
	localparam int CTRL_MIRROR = 3;
	localparam int CTRL_XFER   = 6;
	localparam int CTRL_IRQ    = 7;

	localparam int DISK_OFS_W = 18; // Offset inside the disk region
	localparam pos_t DISK_END_POS = 16'd65499;
	localparam logic [DISK_OFS_W-1:0] SIDE_OFFSET = 18'd16; // Image header skip
	localparam logic [3:0] DISK_REGION_BASE = 4'b0001;     // $40000
	localparam logic [6:0] WRAM_BANK_BASE = 7'b0000001;    // $08000
	localparam logic [8:0] BIOS_BANK_BASE = 9'd0;

	localparam data_t START_MARK = 8'h80;
	localparam data_t EXT_PORT_VALUE = 8'h80; // Battery good

	// Last byte index per block type, CRC bytes are absent from the image
	localparam pos_t VOLUME_LAST  = 16'h0037;
	localparam pos_t COUNT_LAST   = 16'h0001;
	localparam pos_t HEADER_LAST  = 16'h000F;
	localparam pos_t FSIZE_LO_OFS = 16'h000D;
	localparam pos_t FSIZE_HI_OFS = 16'h000E;

endpackage

//--- design/fds_timer_irq.sv
// Counter only runs while $4023 bit 0 is set; the flag clears one ce after a $4030 read
module fds_timer_irq (
	input  logic           clk,
	input  logic           diskreset,
	input  logic           ce,
	input  fds_pkg::addr_t prg_ain,
	input  fds_pkg::data_t prg_din,
	input  logic           prg_write,
	input  logic           io_enabled,
	input  logic           status_read,
	output logic           timer_irq
);
	import fds_pkg::*;

	logic [15:0] timer_latch;
	logic [15:0] timer_cnt;
	logic        timer_en;
	logic        timer_repeat;

	always_ff @(posedge clk) begin
		if (diskreset) begin
			timer_en <= 1'b0;
			timer_repeat <= 1'b0;
			timer_irq <= 1'b0;
		end else if (ce) begin
			if (timer_en) begin
				if (timer_cnt == 16'd0) begin
					timer_irq <= 1'b1;
					timer_cnt <= timer_latch; // Reload for repeat mode
					if (!timer_repeat)
						timer_en <= 1'b0;
				end else begin
					timer_cnt <= timer_cnt - 1'b1;
				end
			end

			if (prg_write) begin
				case (prg_ain)
					REG_TIMER_LO: timer_latch[7:0] <= prg_din;
					REG_TIMER_HI: timer_latch[15:8] <= prg_din;
					REG_TIMER_CTRL: begin
						timer_repeat <= prg_din[TCTRL_REPEAT];
						timer_en <= prg_din[TCTRL_ENABLE] && io_enabled;
						if (prg_din[TCTRL_ENABLE] && io_enabled)
							timer_cnt <= timer_latch;
						else
							timer_irq <= 1'b0; // Acknowledge by disabling
					end
					default: ;
				endcase
			end

			if (status_read)
				timer_irq <= 1'b0;

			// Disk I/O off stops the timer as well
			if (!io_enabled) begin
				timer_en <= 1'b0;
				timer_irq <= 1'b0;
			end
		end
	end

	assert property (@(posedge clk) disable iff (diskreset)
		$rose(timer_irq) |-> $past(io_enabled))
		else $error("timer interrupt raised with disk I/O disabled");

endmodule

//--- design/fds_top.sv
// Disk side of the mapper only; no audio, no BIOS patches, single disk side
module fds_top #(
	parameter logic [15:0] PRE_GAP_DELAY = 16'd65535,
	parameter logic [15:0] BYTE_DELAY    = 16'd99
) (
	input  logic               clk,
	input  logic               diskreset,
	input  logic               ce,
	input  fds_pkg::addr_t     prg_ain,
	input  logic               prg_read,
	input  logic               prg_write,
	input  fds_pkg::data_t     prg_din,
	input  fds_pkg::data_t     prg_dbus,
	input  logic               eject_btn,
	input  logic [13:0]        chr_ain,    // PPU address
	output fds_pkg::prg_addr_t prg_aout,
	output logic               prg_allow,
	output fds_pkg::data_t     prg_dout,
	output logic               prg_bus_write,
	output logic               irq,
	output logic               vram_a10
);
	import fds_pkg::*;

	logic timer_irq;
	logic io_enabled;
	logic status_read;
	logic byte_ready;
	logic disk_irq;
	logic disk_end;
	logic drive_ready;
	logic disk_access;
	logic vertical;
	pos_t disk_pos;

	fds_timer_irq timer0 (.*);

	fds_disk_drive #(
		.PRE_GAP_DELAY(PRE_GAP_DELAY),
		.BYTE_DELAY(BYTE_DELAY)
	) drive0 (.*);

	fds_bus_map map0 (.*);

	assign irq = timer_irq | disk_irq;
	assign vram_a10 = vertical ? chr_ain[10] : chr_ain[11]; // Mirroring from $4025 bit 3

endmodule

//--- files.f
+incdir+include
design/fds_pkg.sv
design/fds_timer_irq.sv
design/fds_disk_drive.sv
design/fds_bus_map.sv
design/fds_top.sv
sim/fds_tb.sv

//--- include/fds_tb_ref.svh
// Expected values for the testbench assume one disk side and need fds_pkg compiled first
`ifndef FDS_TB_REF_SVH
`define FDS_TB_REF_SVH

// Expected PRG address worked out from the memory map
function automatic fds_pkg::prg_addr_t expected_prg_addr(input fds_pkg::addr_t a,
		input logic access, input fds_pkg::pos_t pos);
	if (access)
		return 22'h040000 + 22'd16 + 22'(pos);
	if (a >= 16'h6000 && a <= 16'hDFFF)
		return 22'h008000 + 22'(a[14:0]);
	return 22'(a[12:0]);
endfunction

function automatic logic memory_allowed(input fds_pkg::addr_t a, input logic read,
		input logic bus_write, input logic access);
	return (a >= 16'h6000 && a <= 16'hDFFF) || access || (read && a >= 16'h8000 && !bus_write);
endfunction

function automatic logic drive_is_ready(input logic motor, input logic rewind,
		input logic disk_end, input logic eject);
	return motor && !rewind && !disk_end && !eject;
endfunction

// Returns 1 when the mapper drives the data bus at this address
function automatic logic status_byte(input fds_pkg::addr_t a, input logic timer_irq,
		input logic byte_ready, input logic disk_end, input logic ready, input logic eject,
		output fds_pkg::data_t d);
	d = 8'h00;
	case (a)
		16'h4030: d = {1'b0, disk_end, 4'b0000, byte_ready, timer_irq};
		16'h4032: d = {5'b01000, eject, !ready, eject};
		16'h4033: d = 8'h80; // Battery good
		default: return 1'b0;
	endcase
	return 1'b1;
endfunction

function automatic fds_pkg::pos_t header_file_size(input fds_pkg::data_t lo,
		input fds_pkg::data_t hi);
	return {hi, lo};
endfunction

// Index of the last byte of a block with the type byte at index 0
function automatic fds_pkg::pos_t block_last_index(input logic [2:0] btype,
		input fds_pkg::pos_t fsize);
	case (btype)
		3'd1: return 16'h0037;
		3'd2: return 16'h0001;
		3'd3: return 16'h000F;
		3'd4: return fsize;
		default: return 16'hFFFF;
	endcase
endfunction

`endif

//--- sim/fds_tb.sv
// Uses drive delays of 40 and 9 with ce on every third clock and an image model of one side
module fds_tb;
	import fds_pkg::*;

	`include "fds_tb_ref.svh"

	localparam int HDR_START = 58;  // File header block in the image
	localparam int DATA_START = 74;

	logic        clk;
	logic        diskreset;
	logic        ce = 1'b0;
	logic [1:0]  ce_phase = 2'd0;
	addr_t       prg_ain;
	logic        prg_read;
	logic        prg_write;
	data_t       prg_din;
	data_t       prg_dbus;
	logic        eject_btn;
	logic [13:0] chr_ain;
	prg_addr_t   prg_aout;
	logic        prg_allow;
	data_t       prg_dout;
	logic        prg_bus_write;
	logic        irq;
	logic        vram_a10;

	data_t       img [256];
	prg_addr_t   got_aout;
	data_t       got_dout;
	data_t       got_dbus;
	logic        got_bw;
	logic        got_allow;
	int          checks = 0;
	int          errors = 0;

	fds_top #(
		.PRE_GAP_DELAY(16'd40),
		.BYTE_DELAY(16'd9)
	) dut0 (.*);

	assign prg_dbus = img[8'(prg_aout - 22'h040010)]; // Disk image as async memory

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		ce_phase <= (ce_phase == 2'd2) ? 2'd0 : ce_phase + 2'd1;
		ce <= (ce_phase == 2'd1);
	end

	task automatic report_and_finish();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		errors++;
		$display("Timed out at %0t waiting for %s", $time, what);
		report_and_finish();
	endtask

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Returns on a rising edge at which the DUT sees ce high
	task automatic ce_tick();
		int n;
		@(posedge clk);
		n = 0;
		while (!ce && n < 4) begin
			@(posedge clk);
			n++;
		end
		if (!ce)
			abort_on_timeout("a ce strobe");
	endtask

	task automatic bus_write(input addr_t a, input data_t d);
		ce_tick();
		prg_ain <= a;
		prg_din <= d;
		prg_write <= 1'b1;
		ce_tick();
		prg_write <= 1'b0;
	endtask

	task automatic bus_read(input addr_t a, input logic rd);
		ce_tick();
		prg_ain <= a;
		prg_read <= rd;
		@(negedge clk); // Outputs settled before the access is taken
		got_aout = prg_aout;
		got_dout = prg_dout;
		got_dbus = prg_dbus;
		got_bw = prg_bus_write;
		got_allow = prg_allow;
		ce_tick();
		prg_read <= 1'b0;
	endtask

	// Counts ce cycles until irq starting with the next ce
	task automatic wait_irq(input int limit, output int n);
		n = 0;
		do begin
			ce_tick();
			@(negedge clk);
			n++;
		end while (!irq && n < limit);
		if (!irq)
			abort_on_timeout("the interrupt line");
	endtask

	task automatic check_drive_status(input logic motor, input logic rewind);
		data_t d;
		logic  hit;
		bus_read(16'h4032, 1'b1);
		hit = status_byte(16'h4032, 1'b0, 1'b0, 1'b0,
			drive_is_ready(motor, rewind, 1'b0, eject_btn), eject_btn, d);
		compare("$4032 data", got_dout, d);
		compare("$4032 bus drive", got_bw, hit);
	endtask

	task automatic sweep_address_map();
		addr_t corner [8];
		addr_t a;
		logic  rd;
		logic  access;
		logic  hit;
		data_t d;
		int    i;
		corner = '{16'h4030, 16'h4031, 16'h4032, 16'h4033,
			16'h5FFF, 16'h6000, 16'hDFFF, 16'hE000};
		@(negedge clk);
		compare("vram_a10 horizontal", vram_a10, chr_ain[11]);
		for (i = 0; i < 48; i++) begin
			a = (i < 8) ? corner[i] : addr_t'($urandom);
			rd = (i < 8) ? 1'b1 : 1'($urandom);
			bus_read(a, rd);
			access = rd && (a == 16'h4031);
			hit = status_byte(a, 1'b0, 1'b0, 1'b0, 1'b0, eject_btn, d);
			compare("prg_aout", got_aout, expected_prg_addr(a, access, 16'd0));
			compare("prg_bus_write", got_bw, hit);
			compare("prg_dout", got_dout, d);
			compare("prg_allow", got_allow, memory_allowed(a, rd, hit, access));
		end
	endtask

	task automatic exercise_timer();
		logic [15:0] latch;
		data_t       d;
		logic        hit;
		int          n;
		latch = 16'($urandom % 200);
		bus_write(16'h4023, 8'h01); // Disk I/O on
		bus_write(16'h4020, latch[7:0]);
		bus_write(16'h4021, latch[15:8]);
		bus_write(16'h4022, 8'h02); // One shot
		wait_irq(300, n);
		compare("timer delay", n, latch + 1);
		bus_read(16'h4030, 1'b1);
		hit = status_byte(16'h4030, 1'b1, 1'b0, 1'b0, 1'b0, eject_btn, d);
		compare("$4030 with timer flag", got_dout, d);
		compare("$4030 bus drive", got_bw, hit);
		repeat (latch + 20) ce_tick();
		@(negedge clk);
		compare("irq after acknowledge", irq, 1'b0);
		bus_read(16'h4030, 1'b1);
		hit = status_byte(16'h4030, 1'b0, 1'b0, 1'b0, 1'b0, eject_btn, d);
		compare("$4030 after acknowledge", got_dout, d);
	endtask

	// Reads a block and two more bytes that must not move the head
	task automatic read_block(input int start, input int last);
		int n;
		int i;
		int exp_pos;
		bus_write(16'h4025, 8'h85); // Motor on, read mode, transfer off
		bus_write(16'h4025, 8'hC5); // Transfer on with byte IRQ
		for (i = 0; i <= last + 2; i++) begin
			wait_irq(200, n);
			bus_read(16'h4031, 1'b1);
			exp_pos = start + ((i > last) ? last + 1 : i);
			compare("disk address", got_aout, expected_prg_addr(16'h4031, 1'b1, 16'(exp_pos)));
			compare("disk data", got_dbus, img[exp_pos]);
			compare("disk allow", got_allow, memory_allowed(16'h4031, 1'b1, 1'b0, 1'b1));
		end
	endtask

	task automatic walk_disk_image();
		pos_t fsize;
		fsize = header_file_size(img[HDR_START + 13], img[HDR_START + 14]);
		read_block(0, block_last_index(img[0][2:0], 16'd0));
		@(negedge clk);
		compare("vram_a10 vertical", vram_a10, chr_ain[10]);
		check_drive_status(1'b1, 1'b0);
		read_block(56, block_last_index(img[56][2:0], 16'd0));
		read_block(HDR_START, block_last_index(img[HDR_START][2:0], 16'd0));
		read_block(DATA_START, block_last_index(img[DATA_START][2:0], fsize));
		bus_write(16'h4025, 8'h87); // Head back to the start
		check_drive_status(1'b1, 1'b1);
		read_block(0, block_last_index(img[0][2:0], 16'd0));
	endtask

	initial begin
		logic [15:0] data_len;
		int          i;
		void'($urandom(7603));
		diskreset <= 1'b1;
		prg_ain <= '0;
		prg_read <= 1'b0;
		prg_write <= 1'b0;
		prg_din <= '0;
		eject_btn <= 1'b0;
		chr_ain <= {2'($urandom), 2'b10, 10'($urandom)}; // A11 high and A10 low
		for (i = 0; i < 256; i++)
			img[i] = data_t'($urandom);
		data_len = 16'(8 + $urandom % 16);
		img[0] = 8'h01;   // Volume
		img[56] = 8'h02;  // File count
		img[57] = 8'h01;
		img[HDR_START] = 8'h03;
		img[HDR_START + 13] = data_len[7:0];
		img[HDR_START + 14] = data_len[15:8];
		img[DATA_START] = 8'h04;
		repeat (16) @(posedge clk);
		diskreset <= 1'b0;
		sweep_address_map();
		exercise_timer();
		eject_btn <= 1'b1;
		check_drive_status(1'b0, 1'b0);
		eject_btn <= 1'b0;
		check_drive_status(1'b0, 1'b0);
		bus_read(16'h4033, 1'b1);
		compare("$4033 data", got_dout, 8'h80);
		walk_disk_image();
		report_and_finish();
	end

endmodule
